//--- snap_pkg.sv
`default_nettype none

package snap_pkg;

   // register bus and table entry widths
   localparam int DATA_WIDTH     = 32;
   localparam int MEM_WIDTH      = 36;
   localparam int PART_CNT       = 2;
   localparam int ENTRY_CNT      = 128;
   localparam int BYTES_PER_WORD = 4;

   localparam int ADDR_WIDTH = 12;
   localparam int IDX_WIDTH  = $clog2(ENTRY_CNT);
   localparam int PART_BITS  = $clog2(PART_CNT);
   localparam int WORD_SHIFT = $clog2(BYTES_PER_WORD);

   // bits of an entry above the low bus word
   localparam int HI_WIDTH = MEM_WIDTH - DATA_WIDTH;

   // byte address of entry 0, low word
   localparam logic [ADDR_WIDTH-1:0] TABLE_BASE = 12'h400;

   // cycles from memory request to memory acknowledge
   localparam int MEM_LATENCY   = 3;
   localparam int LAT_CNT_WIDTH = $clog2(MEM_LATENCY + 1);

   // returned for entries that were never written
   localparam logic [MEM_WIDTH-1:0] TABLE_RST_VALUE = 36'hA_5A5A_5A5A;

   typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [DATA_WIDTH-1:0] reg_data_t;
   typedef logic [IDX_WIDTH-1:0]  entry_idx_t;
   typedef logic [MEM_WIDTH-1:0]  mem_word_t;

   // one-hot, bit 0 low word at offset 0, bit 1 high word at offset 4
   typedef logic [PART_CNT-1:0] part_sel_t;

   typedef enum logic [1:0] {
      IDLE,
      SNAPSHOT,
      OP_DATA
   } snap_state_e;

   // one register bus request, held until ack
   typedef struct packed {
      logic      rd_en;
      logic      wr_en;
      reg_addr_t addr;
      reg_data_t wr_data;
   } reg_req_t;

   // command to the table memory
   typedef struct packed {
      logic       rd_en;
      logic       wr_en;
      entry_idx_t idx;
      mem_word_t  wr_data;
   } mem_cmd_t;

endpackage

`default_nettype wire

//--- snap_ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module snap_ctrl_fsm
   import snap_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req_vld,
   input  logic        mem_access,
   input  logic        is_read,
   input  logic        entry_vld,
   input  logic        write_protect,
   input  logic        mem_ack,
   input  logic        mem_ack_d,
   output snap_state_e state,
   output logic        mem_start,
   output logic        ack_vld
);

   snap_state_e state_nxt;
   logic        mem_go;

   // low-word access that really touches memory
   // protected writes and reads of unwritten entries are served directly
   assign mem_go = mem_access & (is_read ? entry_vld : !write_protect);

   always_comb begin
      state_nxt = state;
      ack_vld   = 1'b0;
      case (state)
         IDLE: begin
            if (req_vld) begin
               state_nxt = mem_go ? SNAPSHOT : OP_DATA;
            end
         end
         SNAPSHOT: begin
            // reads wait one more cycle for the registered memory data
            ack_vld = is_read ? mem_ack_d : mem_ack;
            if (ack_vld) begin
               state_nxt = IDLE;
            end
         end
         OP_DATA: begin
            ack_vld   = 1'b1;
            state_nxt = IDLE;
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // one pulse on entering SNAPSHOT
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_start <= 1'b0;
      end else begin
         mem_start <= (state == IDLE) & req_vld & mem_go;
      end
   end

endmodule

`default_nettype wire

//--- mem_latency_timer.sv
`timescale 1ns/10ps
`default_nettype none

module mem_latency_timer
   import snap_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   output logic done,
   output logic done_d
);

   logic [LAT_CNT_WIDTH-1:0] cnt_q;

   // load on start, then count down to zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (start) begin
         cnt_q <= LAT_CNT_WIDTH'(MEM_LATENCY);
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // high in the cycle the count steps to zero
   assign done = (cnt_q == LAT_CNT_WIDTH'(1));

   // registered memory data is usable one cycle later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         done_d <= 1'b0;
      end else begin
         done_d <= done;
      end
   end

endmodule

`default_nettype wire

//--- snap_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module snap_datapath
   import snap_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  reg_req_t    req,
   input  logic        req_vld,
   input  snap_state_e state,
   input  logic        entry_vld,
   input  logic        mem_ack_d,
   input  mem_word_t   mem_rd_data,
   output logic        mem_access,
   output logic        is_read,
   output entry_idx_t  entry_idx,
   output mem_cmd_t    mem_cmd,
   output reg_data_t   rd_data
);

   reg_addr_t  offset;
   reg_addr_t  word_off;
   part_sel_t  part_sel;
   part_sel_t  part_sel_q;
   entry_idx_t idx;
   entry_idx_t idx_q;
   logic       entry_vld_q;
   logic       req_take;
   logic       low_rd_done;
   mem_word_t  load_val;
   mem_word_t  snap_q;

   // partition and entry decode inside the table window
   assign offset   = req.addr - TABLE_BASE;
   assign word_off = offset >> WORD_SHIFT;
   assign part_sel = part_sel_t'(1) << word_off[PART_BITS-1:0];
   assign idx      = word_off[PART_BITS +: IDX_WIDTH];

   assign req_take   = req_vld & (state == IDLE);
   assign mem_access = (req.rd_en | req.wr_en) & part_sel[0];
   assign is_read    = req.rd_en;

   // decoded index while idle so the valid bit is ready at request time
   assign entry_idx = (state == IDLE) ? idx : idx_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         part_sel_q  <= '0;
         idx_q       <= '0;
         entry_vld_q <= 1'b0;
      end else if (req_take) begin
         part_sel_q  <= part_sel;
         idx_q       <= idx;
         entry_vld_q <= entry_vld;
      end
   end

   // low read ends in OP_DATA (unwritten entry) or one cycle after mem ack
   assign low_rd_done = req.rd_en & part_sel_q[0] &
                        ((state == OP_DATA) | ((state == SNAPSHOT) & mem_ack_d));

   assign load_val = entry_vld_q ? mem_rd_data : TABLE_RST_VALUE;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_q <= '0;
      end else if (low_rd_done) begin
         snap_q <= load_val;
      end else if (req_take & req.wr_en) begin
         if (part_sel[1]) begin
            snap_q[MEM_WIDTH-1:DATA_WIDTH] <= req.wr_data[HI_WIDTH-1:0];
         end
         if (part_sel[0]) begin
            snap_q[DATA_WIDTH-1:0] <= req.wr_data;
         end
      end
   end

   // only reached in SNAPSHOT, so protection and validity are already applied
   always_comb begin
      mem_cmd.rd_en   = (state == SNAPSHOT) & req.rd_en & part_sel_q[0];
      mem_cmd.wr_en   = (state == SNAPSHOT) & req.wr_en & part_sel_q[0];
      mem_cmd.idx     = idx_q;
      mem_cmd.wr_data = {snap_q[MEM_WIDTH-1:DATA_WIDTH], req.wr_data};
   end

   always_comb begin
      if (part_sel_q[1]) begin
         rd_data = {{(DATA_WIDTH-HI_WIDTH){1'b0}}, snap_q[MEM_WIDTH-1:DATA_WIDTH]};
      end else if (low_rd_done) begin
         // snapshot loads at the end of this cycle
         rd_data = load_val[DATA_WIDTH-1:0];
      end else begin
         rd_data = snap_q[DATA_WIDTH-1:0];
      end
   end

endmodule

`default_nettype wire

//--- entry_valid_table.sv
`timescale 1ns/10ps
`default_nettype none

module entry_valid_table
   import snap_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  entry_idx_t idx,
   input  mem_cmd_t   mem_cmd,
   input  logic       mem_ack,
   output logic       entry_vld
);

   logic [ENTRY_CNT-1:0] vld_q;

   // set by the first committed write, never cleared
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else if (mem_ack & mem_cmd.wr_en) begin
         vld_q[mem_cmd.idx] <= 1'b1;
      end
   end

   assign entry_vld = vld_q[idx];

endmodule

`default_nettype wire

//--- table_mem.sv
`timescale 1ns/10ps
`default_nettype none

module table_mem
   import snap_pkg::*;
(
   input  logic      clk,
   input  mem_cmd_t  mem_cmd,
   input  logic      mem_ack,
   output mem_word_t rd_data
);

   mem_word_t mem_q [ENTRY_CNT];

   // commands take effect in the ack cycle
   always_ff @(posedge clk) begin
      if (mem_ack & mem_cmd.wr_en) begin
         mem_q[mem_cmd.idx] <= mem_cmd.wr_data;
      end
   end

   // read data valid the cycle after ack
   always_ff @(posedge clk) begin
      if (mem_ack & mem_cmd.rd_en) begin
         rd_data <= mem_q[mem_cmd.idx];
      end
   end

endmodule

`default_nettype wire

//--- snap_table_top.sv
`timescale 1ns/10ps
`default_nettype none

module snap_table_top
   import snap_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  reg_req_t  req,
   input  logic      req_vld,
   input  logic      write_protect,
   output logic      ack_vld,
   output reg_data_t rd_data
);

   snap_state_e state;
   logic        mem_access;
   logic        is_read;
   logic        entry_vld;
   logic        mem_start;
   logic        mem_ack;
   logic        mem_ack_d;
   entry_idx_t  entry_idx;
   mem_cmd_t    mem_cmd;
   mem_word_t   mem_rd_data;

   snap_ctrl_fsm u_snap_ctrl_fsm (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_vld       (req_vld),
      .mem_access    (mem_access),
      .is_read       (is_read),
      .entry_vld     (entry_vld),
      .write_protect (write_protect),
      .mem_ack       (mem_ack),
      .mem_ack_d     (mem_ack_d),
      .state         (state),
      .mem_start     (mem_start),
      .ack_vld       (ack_vld)
   );

   mem_latency_timer u_mem_latency_timer (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (mem_start),
      .done   (mem_ack),
      .done_d (mem_ack_d)
   );

   snap_datapath u_snap_datapath (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .req_vld     (req_vld),
      .state       (state),
      .entry_vld   (entry_vld),
      .mem_ack_d   (mem_ack_d),
      .mem_rd_data (mem_rd_data),
      .mem_access  (mem_access),
      .is_read     (is_read),
      .entry_idx   (entry_idx),
      .mem_cmd     (mem_cmd),
      .rd_data     (rd_data)
   );

   entry_valid_table u_entry_valid_table (
      .clk       (clk),
      .rst_n     (rst_n),
      .idx       (entry_idx),
      .mem_cmd   (mem_cmd),
      .mem_ack   (mem_ack),
      .entry_vld (entry_vld)
   );

   table_mem u_table_mem (
      .clk     (clk),
      .mem_cmd (mem_cmd),
      .mem_ack (mem_ack),
      .rd_data (mem_rd_data)
   );

endmodule

`default_nettype wire

//--- tb_snap_table.sv
`timescale 1ns/10ps
`default_nettype none

module tb_snap_table
   import snap_pkg::*;
();

   typedef struct packed {
      logic       is_wr;
      logic       hi;
      logic       wp;
      entry_idx_t idx;
      reg_data_t  data;
   } step_t;

   logic      clk;
   logic      rst_n;
   reg_req_t  req;
   logic      req_vld;
   logic      write_protect;
   logic      ack_vld;
   reg_data_t rd_data;

   step_t steps[$];
   string names[$];

   // reference model of the table, the valid bits and the snapshot
   mem_word_t model_mem [ENTRY_CNT];
   logic      model_vld [ENTRY_CNT];
   mem_word_t model_snap;

   int   pass_cnt;
   int   fail_cnt;
   logic timed_out;

   snap_table_top u_snap_table_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .req_vld       (req_vld),
      .write_protect (write_protect),
      .ack_vld       (ack_vld),
      .rd_data       (rd_data)
   );

   always #5 clk = ~clk;

   task automatic add_step(input string name, input logic is_wr, input entry_idx_t idx,
                           input logic hi, input reg_data_t data, input logic wp);
      step_t s;
      s.is_wr = is_wr;
      s.hi    = hi;
      s.wp    = wp;
      s.idx   = idx;
      s.data  = data;
      steps.push_back(s);
      names.push_back(name);
   endtask

   task automatic add_read(input string name, input entry_idx_t idx, input logic hi);
      add_step(name, 1'b0, idx, hi, '0, 1'b0);
   endtask

   task automatic add_write(input string name, input entry_idx_t idx, input logic hi,
                            input reg_data_t data, input logic wp);
      add_step(name, 1'b1, idx, hi, data, wp);
   endtask

   // byte address of one partition of one entry
   function automatic reg_addr_t addr_of(input entry_idx_t idx, input logic hi);
      int byte_off;
      byte_off = (int'(idx) * PART_CNT + int'(hi)) * BYTES_PER_WORD;
      return reg_addr_t'(int'(TABLE_BASE) + byte_off);
   endfunction

   // advance the model by one request and give the expected read word
   task automatic predict(input step_t s, output reg_data_t exp);
      exp = '0;
      if (s.is_wr) begin
         if (s.hi) begin
            model_snap[MEM_WIDTH-1:DATA_WIDTH] = s.data[HI_WIDTH-1:0];
         end else begin
            model_snap[DATA_WIDTH-1:0] = s.data;
            if (!s.wp) begin
               model_mem[s.idx] = {model_snap[MEM_WIDTH-1:DATA_WIDTH], s.data};
               model_vld[s.idx] = 1'b1;
            end
         end
      end else if (s.hi) begin
         exp = reg_data_t'(model_snap[MEM_WIDTH-1:DATA_WIDTH]);
      end else begin
         model_snap = model_vld[s.idx] ? model_mem[s.idx] : TABLE_RST_VALUE;
         exp = model_snap[DATA_WIDTH-1:0];
      end
   endtask

   task automatic build_table();
      entry_idx_t rnd_idx[8];
      // never-written entry
      add_read("rst_rd_lo_e5", 7'd5, 1'b0);
      add_read("rst_rd_hi_e5", 7'd5, 1'b1);
      // full 36-bit commit
      // high bits differ from the later snapshot write to entry 20
      add_write("wr_hi_e10", 7'd10, 1'b1, 32'h0000_000c, 1'b0);
      add_write("wr_lo_e10", 7'd10, 1'b0, $urandom, 1'b0);
      add_read("rd_lo_e10", 7'd10, 1'b0);
      add_read("rd_hi_e10", 7'd10, 1'b1);
      // high read comes from the snapshot
      add_write("wr_hi_e20", 7'd20, 1'b1, 32'h0000_0003, 1'b0);
      add_read("snap_rd_hi_e20", 7'd20, 1'b1);
      add_read("snap_rd_hi_e10", 7'd10, 1'b1);
      // protected writes
      add_write("prot_wr_lo_e10", 7'd10, 1'b0, $urandom, 1'b1);
      add_read("prot_rd_lo_e10", 7'd10, 1'b0);
      add_read("prot_rd_hi_e10", 7'd10, 1'b1);
      add_write("prot_wr_lo_e30", 7'd30, 1'b0, $urandom, 1'b1);
      add_read("prot_rd_lo_e30", 7'd30, 1'b0);
      add_read("prot_rd_hi_e30", 7'd30, 1'b1);
      // random entries, read back in reverse order
      for (int k = 0; k < 8; k++) begin
         rnd_idx[k] = entry_idx_t'($urandom % ENTRY_CNT);
         add_write($sformatf("rnd_wr_hi_%0d", k), rnd_idx[k], 1'b1, $urandom, 1'b0);
         add_write($sformatf("rnd_wr_lo_%0d", k), rnd_idx[k], 1'b0, $urandom, 1'b0);
      end
      for (int k = 7; k >= 0; k--) begin
         add_read($sformatf("rnd_rd_lo_%0d", k), rnd_idx[k], 1'b0);
         add_read($sformatf("rnd_rd_hi_%0d", k), rnd_idx[k], 1'b1);
      end
      // both ends of the window
      add_write("wr_hi_e127", 7'd127, 1'b1, $urandom, 1'b0);
      add_write("wr_lo_e127", 7'd127, 1'b0, $urandom, 1'b0);
      add_write("wr_lo_e0", 7'd0, 1'b0, $urandom, 1'b0);
      add_read("rd_lo_e127", 7'd127, 1'b0);
      add_read("rd_hi_e127", 7'd127, 1'b1);
      add_read("rd_lo_e0", 7'd0, 1'b0);
      add_read("rd_hi_e0", 7'd0, 1'b1);
      // mixed kinds issued back to back
      add_write("b2b_wr_lo_e50", 7'd50, 1'b0, $urandom, 1'b0);
      add_read("b2b_rd_lo_e50", 7'd50, 1'b0);
      add_write("b2b_wr_hi_e51", 7'd51, 1'b1, $urandom, 1'b0);
      add_write("b2b_wr_lo_e51", 7'd51, 1'b0, $urandom, 1'b1);
      add_read("b2b_rd_hi_e51", 7'd51, 1'b1);
      add_read("b2b_rd_lo_e51", 7'd51, 1'b0);
      add_read("b2b_rd_lo_e50_again", 7'd50, 1'b0);
   endtask

   task automatic apply_step(input int n);
      step_t     s;
      reg_data_t exp;
      int        wait_cnt;
      logic      got_ack;
      logic      ok;
      s = steps[n];
      predict(s, exp);
      @(posedge clk);
      req.rd_en     <= !s.is_wr;
      req.wr_en     <= s.is_wr;
      req.addr      <= addr_of(s.idx, s.hi);
      req.wr_data   <= s.is_wr ? s.data : '0;
      write_protect <= s.wp;
      req_vld       <= 1'b1;
      @(posedge clk);
      req_vld <= 1'b0;
      wait_cnt = 0;
      got_ack  = 1'b0;
      while (!got_ack && wait_cnt < 50) begin
         @(negedge clk);
         if (ack_vld) begin
            got_ack = 1'b1;
         end else begin
            wait_cnt++;
         end
      end
      if (!got_ack) begin
         $display("%s: no ack_vld within 50 cycles", names[n]);
         timed_out = 1'b1;
         fail_cnt++;
         return;
      end
      ok = 1'b1;
      if (!s.is_wr) begin
         assert (rd_data == exp) else begin
            $display("MISMATCH %s expected %08h actual %08h", names[n], exp, rd_data);
            ok = 1'b0;
         end
      end
      if (ok) begin
         pass_cnt++;
         $display("%s: ok", names[n]);
      end else begin
         fail_cnt++;
      end
   endtask

   initial begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      req           = '0;
      req_vld       = 1'b0;
      write_protect = 1'b0;
      pass_cnt      = 0;
      fail_cnt      = 0;
      timed_out     = 1'b0;
      model_snap    = '0;
      for (int i = 0; i < ENTRY_CNT; i++) begin
         model_mem[i] = '0;
         model_vld[i] = 1'b0;
      end
      void'($urandom(32'hafba));
      build_table();
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      for (int n = 0; n < steps.size() && !timed_out; n++) begin
         apply_step(n);
      end
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && !timed_out) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
snap_pkg.sv
snap_ctrl_fsm.sv
mem_latency_timer.sv
snap_datapath.sv
entry_valid_table.sv
table_mem.sv
snap_table_top.sv
tb_snap_table.sv

//--- run_sim.sh
#!/bin/sh
# build and run the snapshot table testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found"
   exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_snap_table -f compile.f -o sim_snap_table
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_snap_table)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
   exit 0
else
   exit 1
fi
